// File: flist.f
+incdir+src
+incdir+testbench
src/snapshot_pkg.sv
src/trace_pkg.sv
src/trace_if.sv
src/snapshot_fifo.sv
src/snapshot_packet_fsm.sv
src/trace_out_slice.sv
src/snapshot_packetizer.sv
testbench/tb_snapshot_packetizer.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the snapshot packetizer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module tb_snapshot_packetizer -f flist.f --Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

./obj_dir/Vtb_snapshot_packetizer > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

# the log decides the result
if grep -q "Testbench failed" sim.log; then
   exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
   echo "simulation ended without a result line"
   exit 1
fi
exit 0

// File: testbench/tb_snapshot_checks.svh
// reference model and compare tasks; included inside the testbench module after its source queues
`ifndef TB_SNAPSHOT_CHECKS_SVH
`define TB_SNAPSHOT_CHECKS_SVH

trace_word_t exp_q[$];          // expected trace words, oldest first
int          err_count    = 0;
int          check_count  = 0;
int          total_words  = 0;  // every expected word so far, drives the timeout
int          test_packets = 0;  // packets queued in the current test

task automatic check_trace_word(input trace_word_t exp, input trace_word_t got);
   check_count++;
   if (got !== exp) begin
      err_count++;
      $display("ERR trace_word: expected %h got %h", exp, got);
   end
endtask

task automatic check_flag(input string name, input logic exp, input logic got);
   check_count++;
   if (got !== exp) begin
      err_count++;
      $display("ERR %s: expected %h got %h", name, exp, got);
   end
endtask

task automatic push_expect(input trace_mark_t mark, input logic [`SNAP_DATA_WIDTH-1:0] data);
   trace_word_t w;
   w.mark = mark;
   w.data = data;
   exp_q.push_back(w);
endtask

// one snapshot group, its final word closes the packet when ends_packet is set
task automatic add_group(input bit is_gpr, input int len, input bit ends_packet);
   snap_word_t w;
   int         i;
   w.kind = SNAP_NONE;
   w.data = '0;
   if (len == 0) begin  // empty source sends a lone NONE, nothing reaches the trace
      if (is_gpr) gpr_src.push_back(w);
      else        stack_src.push_back(w);
   end
   for (i = 0; i < len; i++) begin
      w.data = $urandom;
      if (len == 1)          w.kind = SNAP_SINGLE;
      else if (i == 0)       w.kind = SNAP_FIRST;
      else if (i == len - 1) w.kind = SNAP_LAST;
      else                   w.kind = SNAP_MIDDLE;
      if (is_gpr) gpr_src.push_back(w);
      else        stack_src.push_back(w);
      push_expect((ends_packet && i == len - 1) ? TRACE_LAST : TRACE_PAYLOAD, w.data);
   end
endtask

// header, timestamp, gpr words, then stack words
task automatic add_event(input logic [`SNAP_EV_ID_WIDTH-1:0] id,
                         input logic [`SNAP_TIME_WIDTH-1:0] stamp,
                         input int gpr_len, input int stack_len);
   event_t ev;
   ev.id    = id;
   ev.stamp = stamp;
   ev_src.push_back(ev);
   push_expect(TRACE_HEADER, {{(`SNAP_DATA_WIDTH - `SNAP_EV_ID_WIDTH){1'b0}}, id});
   push_expect((gpr_len == 0 && stack_len == 0) ? TRACE_LAST : TRACE_PAYLOAD, stamp);
   add_group(1'b1, gpr_len, stack_len == 0);  // gpr closes only if stack is empty
   add_group(1'b0, stack_len, 1'b1);
   test_packets++;
   total_words += 2 + gpr_len + stack_len;
endtask

task automatic add_random_event();
   logic [31:0] r;
   r = $urandom;
   add_event(r[`SNAP_EV_ID_WIDTH-1:0], $urandom, int'($urandom % 5), int'($urandom % 5));
endtask

`endif

// File: testbench/tb_snapshot_packetizer.sv
// sources offer words back to back with no idle cycles; group lengths 0 to 4, fixed seed
`include "snapshot_macros.svh"

module tb_snapshot_packetizer
   import snapshot_pkg::*, trace_pkg::*;
();

   localparam int SEED           = 66311;
   localparam int STREAM_EVENTS  = 40;   // tests 3 and 4
   localparam int STALL_EVENTS   = 12;   // well past the event queue depth
   localparam int TIMEOUT_FACTOR = 8;    // cycles allowed per expected word
   localparam int TIMEOUT_SLACK  = 200;

   logic                         clk         = 1'b0;
   logic                         rst         = 1'b1;
   logic [`SNAP_EV_ID_WIDTH-1:0] ev_id       = '0;
   logic [`SNAP_TIME_WIDTH-1:0]  ev_time     = '0;
   logic                         event_valid = 1'b0;
   logic                         ev_ready;
   logic [`SNAP_DATA_WIDTH-1:0]  gpr_data    = '0;
   snap_type_t                   gpr_type    = SNAP_NONE;
   logic                         gpr_valid   = 1'b0;
   logic                         gpr_ready;
   logic [`SNAP_DATA_WIDTH-1:0]  stack_data  = '0;
   snap_type_t                   stack_type  = SNAP_NONE;
   logic                         stack_valid = 1'b0;
   logic                         stack_ready;
   trace_word_t                  trace_word;
   logic                         trace_valid;
   logic                         trace_ready = 1'b1;
   logic                         trace_overflow;

   event_t      ev_src[$];        // words still to offer, head sits on the pins
   snap_word_t  gpr_src[$];
   snap_word_t  stack_src[$];
   int          ready_mode = 0;   // 0 ready high, 1 random, 2 held low
   int          cycles     = 0;
   int          words_seen = 0;
   int          lasts_seen = 0;
   int          tests_run  = 0;
   int          tests_failed = 0;
   int          test_err_start = 0;
   logic        stalled    = 1'b0;  // valid without ready at the last edge
   trace_word_t held_word;

   `include "tb_snapshot_checks.svh"

   snapshot_packetizer dut0 (
      .clk, .rst, .ev_id, .ev_time, .event_valid, .ev_ready,
      .gpr_data, .gpr_type, .gpr_valid, .gpr_ready,
      .stack_data, .stack_type, .stack_valid, .stack_ready,
      .trace_word, .trace_valid, .trace_ready, .trace_overflow
   );

   initial begin
      forever #5 clk = ~clk;
   end

   // source drivers, drop what was taken at this edge then show the next head
   always @(posedge clk) begin
      if (rst) begin
         event_valid <= 1'b0;
         gpr_valid   <= 1'b0;
         stack_valid <= 1'b0;
      end else begin
         if (event_valid && ev_ready) ev_src.delete(0);
         if (gpr_valid && gpr_ready) gpr_src.delete(0);
         if (stack_valid && stack_ready) stack_src.delete(0);
         event_valid <= (ev_src.size() != 0);
         gpr_valid   <= (gpr_src.size() != 0);
         stack_valid <= (stack_src.size() != 0);
         if (ev_src.size() != 0) begin
            ev_id   <= ev_src[0].id;
            ev_time <= ev_src[0].stamp;
         end
         if (gpr_src.size() != 0) begin
            gpr_data <= gpr_src[0].data;
            gpr_type <= gpr_src[0].kind;
         end
         if (stack_src.size() != 0) begin
            stack_data <= stack_src[0].data;
            stack_type <= stack_src[0].kind;
         end
      end
   end

   // output monitor and trace_ready driver
   always @(posedge clk) begin
      if (rst) begin
         trace_ready <= 1'b1;
         stalled = 1'b0;
      end else begin
         if (stalled) begin  // word held since the stalled edge
            check_flag("trace_valid", 1'b1, trace_valid);
            check_trace_word(held_word, trace_word);
         end
         if (trace_valid && trace_ready) begin
            words_seen++;
            if (trace_word.mark == TRACE_LAST) lasts_seen++;
            if (exp_q.size() == 0) begin
               err_count++;
               $display("trace word %h arrived with no packet pending", trace_word);
            end else begin
               check_trace_word(exp_q[0], trace_word);
               exp_q.delete(0);
            end
         end
         stalled   = trace_valid && !trace_ready;
         held_word = trace_word;
         case (ready_mode)
            0:       trace_ready <= 1'b1;
            1:       trace_ready <= 1'($urandom);
            default: trace_ready <= 1'b0;
         endcase
      end
   end

   // limit grows with every queued packet
   always @(posedge clk) begin
      cycles++;
      if (cycles > total_words * TIMEOUT_FACTOR + TIMEOUT_SLACK) begin
         $display("timeout after %0d cycles, %0d words still expected", cycles, exp_q.size());
         $display("Testbench failed");
         $finish;
      end
   end

   task automatic start_test();
      test_err_start = err_count;
      words_seen     = 0;
      lasts_seen     = 0;
      test_packets   = 0;
   endtask

   task automatic end_test(input string name);
      int errs;
      if (lasts_seen != test_packets) begin
         err_count++;
         $display("%0d LAST words seen for %0d packets", lasts_seen, test_packets);
      end
      errs = err_count - test_err_start;
      tests_run++;
      if (errs != 0) tests_failed++;
      $display("test %0d %s: %s, %0d words, %0d errors", tests_run, name,
               (errs == 0) ? "ok" : "FAILED", words_seen, errs);
   endtask

   // all stimulus taken and all expected words out, then a few idle cycles for strays
   task automatic wait_drain();
      while (exp_q.size() != 0 || ev_src.size() != 0 || gpr_src.size() != 0 ||
             stack_src.size() != 0)
         @(negedge clk);
      repeat (4) @(negedge clk);
   endtask

   initial begin
      void'($urandom(SEED));
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);

      start_test();
      check_flag("trace_valid", 1'b0, trace_valid);
      check_flag("trace_overflow", 1'b0, trace_overflow);
      check_flag("ev_ready", 1'b1, ev_ready);
      check_flag("gpr_ready", 1'b1, gpr_ready);
      check_flag("stack_ready", 1'b1, stack_ready);
      end_test("reset_state");

      start_test();
      add_event(16'h5a3c, $urandom, 0, 0);  // both sources NONE
      wait_drain();
      if (words_seen != 2) begin
         err_count++;
         $display("empty snapshot packet gave %0d words instead of 2", words_seen);
      end
      end_test("empty_snapshots");

      start_test();
      repeat (STREAM_EVENTS) add_random_event();
      wait_drain();
      end_test("stream_ready_high");

      start_test();
      ready_mode = 1;
      repeat (STREAM_EVENTS) add_random_event();
      wait_drain();
      end_test("stream_ready_random");

      start_test();
      ready_mode = 2;
      repeat (STALL_EVENTS) add_random_event();
      while (ev_ready) @(negedge clk);  // event queue full
      repeat (2) @(negedge clk);
      check_flag("trace_overflow", 1'b1, trace_overflow);
      ready_mode = 0;
      wait_drain();
      check_flag("trace_overflow", 1'b0, trace_overflow);
      end_test("backpressure");

      $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, check_count, err_count);
      if (err_count == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// File: src/snapshot_packetizer.sv
// snapshot packetizer top; no flit packetization or NoC ids, trace stream leaves as plain ports
`include "snapshot_macros.svh"

module snapshot_packetizer
   import snapshot_pkg::*, trace_pkg::*;
#(
   parameter int EV_DEPTH   = `SNAP_EV_DEPTH,
   parameter int WORD_DEPTH = `SNAP_WORD_DEPTH
) (
   input  logic                         clk,
   input  logic                         rst,
   input  logic [`SNAP_EV_ID_WIDTH-1:0] ev_id,
   input  logic [`SNAP_TIME_WIDTH-1:0]  ev_time,
   input  logic                         event_valid,
   output logic                         ev_ready,
   input  logic [`SNAP_DATA_WIDTH-1:0]  gpr_data,
   input  snap_type_t                   gpr_type,
   input  logic                         gpr_valid,
   output logic                         gpr_ready,
   input  logic [`SNAP_DATA_WIDTH-1:0]  stack_data,
   input  snap_type_t                   stack_type,
   input  logic                         stack_valid,
   output logic                         stack_ready,
   output trace_word_t                  trace_word,
   output logic                         trace_valid,
   input  logic                         trace_ready,
   output logic                         trace_overflow
);

   event_t     ev_in, ev_head;
   snap_word_t gpr_in, gpr_head;
   snap_word_t stack_in, stack_head;
   logic       ev_head_valid, gpr_head_valid, stack_head_valid;
   logic       ev_pop, gpr_pop, stack_pop;

   trace_if trace_bus ();  // assembler to slice

   assign ev_in    = '{id: ev_id, stamp: ev_time};
   assign gpr_in   = '{kind: gpr_type, data: gpr_data};
   assign stack_in = '{kind: stack_type, data: stack_data};

   snapshot_fifo #(.DEPTH(EV_DEPTH), .payload_t(event_t)) ev_fifo (
      .clk, .rst, .in_data(ev_in), .in_valid(event_valid), .in_ready(ev_ready),
      .out_data(ev_head), .out_ready(ev_pop), .out_valid(ev_head_valid)
   );

   snapshot_fifo #(.DEPTH(WORD_DEPTH), .payload_t(snap_word_t)) gpr_fifo (
      .clk, .rst, .in_data(gpr_in), .in_valid(gpr_valid), .in_ready(gpr_ready),
      .out_data(gpr_head), .out_ready(gpr_pop), .out_valid(gpr_head_valid)
   );

   snapshot_fifo #(.DEPTH(WORD_DEPTH), .payload_t(snap_word_t)) stack_fifo (
      .clk, .rst, .in_data(stack_in), .in_valid(stack_valid), .in_ready(stack_ready),
      .out_data(stack_head), .out_ready(stack_pop), .out_valid(stack_head_valid)
   );

   // full flags are the inverted queue readys
   snapshot_packet_fsm packet_fsm (
      .clk, .rst,
      .ev_head, .ev_valid(ev_head_valid), .ev_pop,
      .gpr_head, .gpr_valid(gpr_head_valid), .gpr_pop,
      .stack_head, .stack_valid(stack_head_valid), .stack_pop,
      .ev_full(!ev_ready), .gpr_full(!gpr_ready), .stack_full(!stack_ready),
      .trace(trace_bus.src)
   );

   trace_out_slice out_slice (
      .clk, .rst, .trace(trace_bus.snk),
      .out_word(trace_word), .out_valid(trace_valid), .out_ready(trace_ready),
      .overflow(trace_overflow)
   );

endmodule

// File: src/trace_out_slice.sv
// two entry skid buffer, registered outputs; overflow output lags its input by one cycle
module trace_out_slice
   import trace_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   trace_if.snk        trace,
   output trace_word_t out_word,
   output logic        out_valid,
   input  logic        out_ready,
   output logic        overflow
);

   trace_word_t skid_word;   // second entry, used only when output stalls
   logic        skid_valid;
   logic        in_xfer;
   logic        load_main;

   assign trace.ready = !skid_valid;  // free entry left
   assign in_xfer     = trace.valid && trace.ready;
   assign load_main   = !out_valid || out_ready;  // output reg empty or draining

   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid  <= 1'b0;
         skid_valid <= 1'b0;
         overflow   <= 1'b0;
      end else begin
         overflow <= trace.overflow;
         if (load_main) begin
            out_valid  <= skid_valid || in_xfer;  // skid first, keeps order
            skid_valid <= 1'b0;
         end else if (in_xfer) begin
            skid_valid <= 1'b1;                   // output stalled, park word
         end
      end
   end

   // payload regs
   always_ff @(posedge clk) begin
      if (load_main && skid_valid) begin
         out_word <= skid_word;
      end else if (load_main && in_xfer) begin
         out_word <= trace.word;
      end
      if (!load_main && in_xfer) skid_word <= trace.word;
   end

endmodule

// File: src/snapshot_packet_fsm.sv
// packet assembler, combinational toward trace_if; assumes one snapshot group per source and event
`include "snapshot_macros.svh"

module snapshot_packet_fsm
   import snapshot_pkg::*, trace_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  event_t     ev_head,
   input  logic       ev_valid,
   output logic       ev_pop,
   input  snap_word_t gpr_head,
   input  logic       gpr_valid,
   output logic       gpr_pop,
   input  snap_word_t stack_head,
   input  logic       stack_valid,
   output logic       stack_pop,
   input  logic       ev_full,
   input  logic       gpr_full,
   input  logic       stack_full,
   trace_if.src       trace
);

   localparam int DATA_W = `SNAP_DATA_WIDTH;

   typedef enum logic [1:0] {
      ST_IDLE,   // header word
      ST_TIME,   // timestamp word
      ST_GPR,    // forwarding gpr group
      ST_STACK   // forwarding stack group
   } state_t;

   state_t      state;
   state_t      state_nxt;
   trace_word_t out_word;
   logic        out_valid;
   logic        gpr_none;
   logic        gpr_end;
   logic        stack_none;
   logic        stack_end;

   assign gpr_none   = (gpr_head.kind == SNAP_NONE);
   assign gpr_end    = (gpr_head.kind == SNAP_SINGLE) || (gpr_head.kind == SNAP_LAST);
   assign stack_none = (stack_head.kind == SNAP_NONE);
   assign stack_end  = (stack_head.kind == SNAP_SINGLE) || (stack_head.kind == SNAP_LAST);

   assign trace.word     = out_word;
   assign trace.valid    = out_valid;
   assign trace.overflow = ev_full || gpr_full || stack_full;  // independent of valid

   always_comb begin
      state_nxt = state;
      out_valid = 1'b0;
      out_word  = '{mark: TRACE_PAYLOAD, data: '0};
      ev_pop    = 1'b0;
      gpr_pop   = 1'b0;
      stack_pop = 1'b0;
      case (state)
         ST_IDLE: begin
            out_valid = ev_valid;
            out_word  = '{mark: TRACE_HEADER, data: DATA_W'(ev_head.id)};  // upper bits zero
            if (out_valid && trace.ready) state_nxt = ST_TIME;
         end
         ST_TIME: begin
            // both first snapshot words decide whether time closes the packet
            out_valid     = ev_valid && gpr_valid && stack_valid;
            out_word.data = DATA_W'(ev_head.stamp);
            if (gpr_none && stack_none) out_word.mark = TRACE_LAST;
            if (out_valid && trace.ready) begin
               ev_pop = 1'b1;  // event done once time is out
               if (gpr_none) begin
                  gpr_pop   = 1'b1;        // drop gpr NONE
                  stack_pop = stack_none;  // and stack NONE if packet ends here
                  state_nxt = stack_none ? ST_IDLE : ST_STACK;
               end else begin
                  state_nxt = ST_GPR;
               end
            end
         end
         ST_GPR: begin
            out_valid     = gpr_valid;
            out_word.data = gpr_head.data;
            if (gpr_end && stack_none) out_word.mark = TRACE_LAST;  // no stack words follow
            if (gpr_valid && trace.ready) begin
               gpr_pop = 1'b1;
               if (gpr_end) begin
                  stack_pop = stack_none;  // stack head still valid from TIME
                  state_nxt = stack_none ? ST_IDLE : ST_STACK;
               end
            end
         end
         ST_STACK: begin
            out_valid     = stack_valid;
            out_word.data = stack_head.data;
            if (stack_end) out_word.mark = TRACE_LAST;
            if (stack_valid && trace.ready) begin
               stack_pop = 1'b1;
               if (stack_end) state_nxt = ST_IDLE;
            end
         end
         default: state_nxt = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) state <= ST_IDLE;
      else     state <= state_nxt;
   end

endmodule

// File: src/snapshot_fifo.sv
// single clock queue, one cycle from push to head; in_ready low exactly while full; DEPTH >= 1
module snapshot_fifo #(
   parameter int DEPTH = 4,
   parameter type payload_t = logic [7:0]
) (
   input  logic     clk,
   input  logic     rst,
   input  payload_t in_data,
   input  logic     in_valid,
   output logic     in_ready,
   output payload_t out_data,
   input  logic     out_ready,
   output logic     out_valid
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);
   localparam logic [PTR_W-1:0] PTR_MAX = PTR_W'(DEPTH - 1);  // wrap point for any depth
   localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;  // occupancy
   logic             push;
   logic             pop;

   assign in_ready  = (count != CNT_FULL);
   assign out_valid = (count != '0);
   assign out_data  = mem[rd_ptr];  // head word, meaningful only with out_valid

   assign push = in_valid && in_ready;
   assign pop  = out_valid && out_ready;

   // payload storage
   always_ff @(posedge clk) begin
      if (push) mem[wr_ptr] <= in_data;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= (wr_ptr == PTR_MAX) ? '0 : wr_ptr + 1'b1;
         if (pop)  rd_ptr <= (rd_ptr == PTR_MAX) ? '0 : rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // idle or push and pop together
         endcase
      end
   end

endmodule

// File: src/trace_if.sv
// trace stream between assembler and output slice; valid/ready, word held stable while valid
interface trace_if
   import trace_pkg::*;
();

   trace_word_t word;      // marked trace word
   logic        valid;
   logic        ready;
   logic        overflow;  // level, any input queue full

   // assembler side
   modport src (
      output word, valid, overflow,
      input  ready
   );

   // output slice side
   modport snk (
      input  word, valid, overflow,
      output ready
   );

endinterface

// File: src/trace_pkg.sv
// output trace stream types; a packet is one HEADER word, PAYLOAD words, and one LAST word
`include "snapshot_macros.svh"

package trace_pkg;

   // 2-bit marker in front of each trace word
   typedef enum logic [1:0] {
      TRACE_PAYLOAD = 2'd0,  // timestamp or snapshot word
      TRACE_HEADER  = 2'd1,  // carries the event ID
      TRACE_LAST    = 2'd2   // final word of a packet
   } trace_mark_t;

   // 34 bit trace word, mark on top
   typedef struct packed {
      trace_mark_t                 mark;
      logic [`SNAP_DATA_WIDTH-1:0] data;
   } trace_word_t;

endpackage

// File: src/snapshot_pkg.sv
// input side types; each snapshot source sends exactly one group per event, NONE/SINGLE/FIRST..LAST
`include "snapshot_macros.svh"

package snapshot_pkg;

   // flit kind attached to every snapshot word
   typedef enum logic [2:0] {
      SNAP_NONE   = 3'd0,  // source has nothing for this event
      SNAP_SINGLE = 3'd1,  // one word group
      SNAP_FIRST  = 3'd2,
      SNAP_MIDDLE = 3'd3,
      SNAP_LAST   = 3'd4   // closes a multi word group
   } snap_type_t;

   // gpr or stack word as queued, 35 bits
   typedef struct packed {
      snap_type_t                   kind;
      logic [`SNAP_DATA_WIDTH-1:0]  data;
   } snap_word_t;

   // one event fingerprint, 48 bits
   typedef struct packed {
      logic [`SNAP_EV_ID_WIDTH-1:0] id;
      logic [`SNAP_TIME_WIDTH-1:0]  stamp;  // timestamp
   } event_t;

endpackage

// File: src/snapshot_macros.svh
// widths and queue depths; the timestamp and the event ID must each fit in one data word
`ifndef SNAPSHOT_MACROS_SVH
`define SNAPSHOT_MACROS_SVH

// payload width of one snapshot word and of one trace word
`define SNAP_DATA_WIDTH 32

// event ID as delivered by the event source
`define SNAP_EV_ID_WIDTH 16

// timestamp width, no wider than SNAP_DATA_WIDTH
`define SNAP_TIME_WIDTH 32

// default event queue depth, events waiting for their snapshots
`define SNAP_EV_DEPTH 4

// default depth of the gpr and stack word queues
`define SNAP_WORD_DEPTH 8

`endif
